/* common/mmu_pkg.sv */
// shared widths, opcode and state enums, serial byte and memory request structs
package mmu_pkg;

   //////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////
   localparam int addr_w = 14; // word address, port b
   localparam int data_w = 64; // one memory word

   //////////////////////////////////////////////////
   // host command set, ascii opcodes
   //////////////////////////////////////////////////
   typedef enum logic [7:0] {
      cmd_write = 8'h57, // 'W' addr hi, addr lo, 8 data bytes
      cmd_read  = 8'h52, // 'R' addr hi, addr lo
      cmd_flush = 8'h46  // 'F' one flsh pulse
   } cmd_e;

   // single byte replies
   localparam logic [7:0] reply_ack = 8'h4B; // 'K' after write or flush
   localparam logic [7:0] reply_err = 8'h45; // 'E' unknown opcode

   // controller states, value also goes out on the state pins
   typedef enum logic [3:0] {
      st_idle    = 4'd0, // waiting for opcode
      st_addr_hi = 4'd1,
      st_addr_lo = 4'd2,
      st_data    = 4'd3, // collecting write bytes
      st_write   = 4'd4, // one cycle memory write
      st_read    = 4'd5, // one cycle memory read
      st_send    = 4'd6, // streaming read data back
      st_reply   = 4'd7  // single reply byte
   } ctrl_state_e;

   // byte strobe, used rx to ctrl and ctrl to tx
   typedef struct packed {
      logic       strobe; // one clock wide
      logic [7:0] data;
   } uart_byte_t;

   // port b request to the data memory
   typedef struct packed {
      logic              en;
      logic              we;   // write when en also high
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
   } mem_req_t;

endpackage

/* spart/spart_baud_gen.sv */
// baud rate generator with bit ticks for transmit and 16x ticks for receive
`timescale 1ns/1ps

module spart_baud_gen #(
   parameter int base_div = 868 // clocks per bit at br_cfg 0
) (
   input  logic       clk,
   input  logic       reset,
   input  logic [1:0] br_cfg,  // divisor = base_div >> br_cfg
   output logic       tx_tick, // once per bit
   output logic       rx_tick  // sixteen per bit
);

   localparam int cnt_w = $clog2(base_div + 1);

   logic [1:0]       br_q;     // last rate seen
   logic             rate_chg;
   logic [cnt_w-1:0] new_div;  // bit divisor for the incoming rate
   logic [cnt_w-1:0] bit_div;
   logic [cnt_w-1:0] sub_div;
   logic [cnt_w-1:0] bit_cnt;
   logic [cnt_w-1:0] sub_cnt;

   assign rate_chg = (br_cfg != br_q);
   assign new_div  = cnt_w'(base_div) >> br_cfg;
   assign bit_div  = cnt_w'(base_div) >> br_q;
   // never let the 16x divisor collapse to zero on slow divisors
   assign sub_div  = (bit_div < cnt_w'(16)) ? cnt_w'(1) : (bit_div >> 4);

   always_ff @(posedge clk) begin
      if (reset || rate_chg) begin
         br_q    <= br_cfg;
         bit_cnt <= new_div - 1'b1; // restart both counters together
         sub_cnt <= ((new_div < cnt_w'(16)) ? cnt_w'(1) : (new_div >> 4)) - 1'b1;
         tx_tick <= 1'b0;
         rx_tick <= 1'b0;
      end else begin
         tx_tick <= (bit_cnt == '0);
         rx_tick <= (sub_cnt == '0);
         bit_cnt <= (bit_cnt == '0) ? bit_div - 1'b1 : bit_cnt - 1'b1;
         sub_cnt <= (sub_cnt == '0) ? sub_div - 1'b1 : sub_cnt - 1'b1;
      end
   end

endmodule

/* spart/spart_rx.sv */
// serial receiver, 16x oversampled, 8N1 frames to one byte strobe
`timescale 1ns/1ps

module spart_rx (
   input  logic                clk,
   input  logic                reset,
   input  logic                rxd,     // async line from host
   input  logic                rx_tick, // 16 per bit
   output mmu_pkg::uart_byte_t rx_byte
);

   typedef enum logic [1:0] {
      rx_idle,
      rx_start, // checking start bit at mid point
      rx_data,
      rx_stop
   } rx_state_e;

   rx_state_e  state_q;
   logic       rxd_s1, rxd_s2, rxd_s3; // sync chain, s3 for edge
   logic       start_fall;
   logic [3:0] tick_cnt;               // ticks within a bit
   logic [2:0] bit_cnt;                // data bit index
   logic [7:0] shreg;                  // lsb arrives first
   logic       strobe_q;

   assign start_fall = rxd_s3 & ~rxd_s2;

   // shreg is stable once the frame completes
   assign rx_byte = '{strobe: strobe_q, data: shreg};

   //////////////////////////////////////////////////
   // input synchronizer
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         rxd_s1 <= 1'b1; // line idles high
         rxd_s2 <= 1'b1;
         rxd_s3 <= 1'b1;
      end else begin
         rxd_s1 <= rxd;
         rxd_s2 <= rxd_s1;
         rxd_s3 <= rxd_s2;
      end
   end

   //////////////////////////////////////////////////
   // frame fsm
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state_q  <= rx_idle;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         strobe_q <= 1'b0;
      end else begin
         strobe_q <= 1'b0;
         case (state_q)
            rx_idle: if (start_fall) begin
               state_q  <= rx_start;
               tick_cnt <= '0;
            end
            rx_start: if (rx_tick) begin
               tick_cnt <= tick_cnt + 1'b1;
               if (tick_cnt == 4'd7) begin // half a bit in
                  tick_cnt <= '0;
                  bit_cnt  <= '0;
                  state_q  <= rxd_s2 ? rx_idle : rx_data; // glitch, back off
               end
            end
            rx_data: if (rx_tick) begin
               tick_cnt <= tick_cnt + 1'b1;
               if (tick_cnt == 4'd15) begin // mid bit
                  shreg   <= {rxd_s2, shreg[7:1]};
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     state_q <= rx_stop;
               end
            end
            rx_stop: if (rx_tick) begin
               tick_cnt <= tick_cnt + 1'b1;
               if (tick_cnt == 4'd15) begin
                  strobe_q <= rxd_s2; // bad stop bit drops the byte
                  state_q  <= rx_idle;
               end
            end
            default: state_q <= rx_idle;
         endcase
      end
   end

endmodule

/* spart/spart_tx.sv */
// serial transmitter, one 8N1 frame per byte strobe
`timescale 1ns/1ps

module spart_tx (
   input  logic                clk,
   input  logic                reset,
   input  logic                tx_tick, // one per bit
   input  mmu_pkg::uart_byte_t tx_byte,
   output logic                txd,
   output logic                tx_busy
);

   logic [9:0] frame;   // stop, data msb..lsb, start
   logic [3:0] bit_cnt; // bits already put on the line

   //////////////////////////////////////////////////
   // frame shifter
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         txd     <= 1'b1; // idle mark
         tx_busy <= 1'b0;
         bit_cnt <= '0;
      end else if (!tx_busy) begin
         txd <= 1'b1;
         if (tx_byte.strobe) begin
            tx_busy <= 1'b1;
            bit_cnt <= '0;
         end
      end else if (tx_tick) begin
         if (bit_cnt == 4'd10) begin
            // stop bit has had its full period
            tx_busy <= 1'b0;
            txd     <= 1'b1;
         end else begin
            txd     <= frame[0];
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   // payload, loaded on the strobe and shifted per tick
   always_ff @(posedge clk) begin
      if (!tx_busy && tx_byte.strobe)
         frame <= {1'b1, tx_byte.data, 1'b0};
      else if (tx_busy && tx_tick)
         frame <= {1'b1, frame[9:1]}; // refill with mark
   end

endmodule

/* design/data_mem.sv */
// 64-bit data memory, single port b with registered read
`timescale 1ns/1ps

module data_mem #(
   parameter int depth_words = 16384 // power of two
) (
   input  logic              clk,
   input  mmu_pkg::mem_req_t mem_req,
   output logic [63:0]       rdata
);

   localparam int aw = $clog2(depth_words);

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////
   logic [mmu_pkg::data_w-1:0] mem [depth_words];
   logic [aw-1:0]              word_addr;

   // high address bits ignored so access wraps at depth
   assign word_addr = mem_req.addr[aw-1:0];

   // write port
   always_ff @(posedge clk) begin
      if (mem_req.en && mem_req.we)
         mem[word_addr] <= mem_req.data;
   end

   // read port
   // output holds until the next read, so the controller can
   // stream bytes straight from it
   always_ff @(posedge clk) begin
      if (mem_req.en && !mem_req.we)
         rdata <= mem[word_addr];
   end

endmodule

/* design/mmu_cmd_ctrl.sv */
// command parser and sequencer for serial writes, reads, flush and replies
`timescale 1ns/1ps

module mmu_cmd_ctrl (
   input  logic                 clk,
   input  logic                 reset,
   input  mmu_pkg::uart_byte_t  rx_byte, // from spart_rx
   input  logic                 tx_busy,
   output mmu_pkg::uart_byte_t  tx_byte, // to spart_tx
   output mmu_pkg::mem_req_t    mem_req, // port b
   input  logic [63:0]          rdata,   // held from last read
   output logic                 flsh,
   output mmu_pkg::ctrl_state_e state
);

   mmu_pkg::ctrl_state_e        state_q;
   logic                        is_write;  // W vs R after the address
   logic [mmu_pkg::addr_w-1:0]  addr_q;
   logic [mmu_pkg::data_w-1:0]  wdata_q;   // msb byte arrives first
   logic [2:0]                  byte_cnt;
   logic [7:0]                  reply_q;
   logic                        tx_strobe_q;
   logic [7:0]                  tx_data_q;
   logic                        tx_ready;  // tx idle and no strobe in flight

   assign state    = state_q;
   assign tx_byte  = '{strobe: tx_strobe_q, data: tx_data_q};
   // busy only rises the clock after our strobe
   assign tx_ready = !tx_busy && !tx_strobe_q;

   //////////////////////////////////////////////////
   // memory request, decoded from state
   //////////////////////////////////////////////////
   always_comb begin
      mem_req.en   = (state_q == mmu_pkg::st_write) || (state_q == mmu_pkg::st_read);
      mem_req.we   = (state_q == mmu_pkg::st_write);
      mem_req.addr = addr_q;
      mem_req.data = wdata_q;
   end

   //////////////////////////////////////////////////
   // sequencer
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state_q     <= mmu_pkg::st_idle;
         is_write    <= 1'b0;
         byte_cnt    <= '0;
         flsh        <= 1'b0;
         tx_strobe_q <= 1'b0;
      end else begin
         flsh        <= 1'b0; // single clock pulse
         tx_strobe_q <= 1'b0;
         case (state_q)
            mmu_pkg::st_idle: if (rx_byte.strobe) begin
               case (mmu_pkg::cmd_e'(rx_byte.data))
                  mmu_pkg::cmd_write: begin
                     is_write <= 1'b1;
                     state_q  <= mmu_pkg::st_addr_hi;
                  end
                  mmu_pkg::cmd_read: begin
                     is_write <= 1'b0;
                     state_q  <= mmu_pkg::st_addr_hi;
                  end
                  mmu_pkg::cmd_flush: begin
                     flsh    <= 1'b1;
                     reply_q <= mmu_pkg::reply_ack;
                     state_q <= mmu_pkg::st_reply;
                  end
                  default: begin
                     reply_q <= mmu_pkg::reply_err; // unknown opcode
                     state_q <= mmu_pkg::st_reply;
                  end
               endcase
            end
            mmu_pkg::st_addr_hi: if (rx_byte.strobe) begin
               addr_q[13:8] <= rx_byte.data[5:0]; // top two bits dropped
               state_q      <= mmu_pkg::st_addr_lo;
            end
            mmu_pkg::st_addr_lo: if (rx_byte.strobe) begin
               addr_q[7:0] <= rx_byte.data;
               byte_cnt    <= '0;
               state_q     <= is_write ? mmu_pkg::st_data : mmu_pkg::st_read;
            end
            mmu_pkg::st_data: if (rx_byte.strobe) begin
               wdata_q  <= {wdata_q[55:0], rx_byte.data};
               byte_cnt <= byte_cnt + 1'b1;
               if (byte_cnt == 3'd7)
                  state_q <= mmu_pkg::st_write;
            end
            mmu_pkg::st_write: begin
               reply_q <= mmu_pkg::reply_ack; // write lands this edge
               state_q <= mmu_pkg::st_reply;
            end
            mmu_pkg::st_read: begin
               byte_cnt <= '0; // rdata valid next clock
               state_q  <= mmu_pkg::st_send;
            end
            mmu_pkg::st_send: if (tx_ready) begin
               tx_strobe_q <= 1'b1;
               tx_data_q   <= rdata[8*(3'd7 - byte_cnt) +: 8]; // msb byte first
               byte_cnt    <= byte_cnt + 1'b1;
               if (byte_cnt == 3'd7)
                  state_q <= mmu_pkg::st_idle;
            end
            mmu_pkg::st_reply: if (tx_ready) begin
               tx_strobe_q <= 1'b1;
               tx_data_q   <= reply_q;
               state_q     <= mmu_pkg::st_idle;
            end
            default: state_q <= mmu_pkg::st_idle;
         endcase
      end
   end

endmodule

/* design/mmu_board.sv */
// board top, serial port, command controller and data memory
`timescale 1ns/1ps

module mmu_board #(
   parameter int base_div    = 868,  // 115200 baud at 100 mhz
   parameter int depth_words = 16384
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       rxd,    // rs232 from host
   input  logic [1:0] br_cfg, // baud select switches
   output logic       txd,    // rs232 to host
   output logic [3:0] state,  // controller state leds
   output logic       flsh
);

   logic                       tx_tick;
   logic                       rx_tick;
   logic                       tx_busy;
   mmu_pkg::uart_byte_t        rx_byte;
   mmu_pkg::uart_byte_t        tx_byte;
   mmu_pkg::mem_req_t          mem_req;
   logic [mmu_pkg::data_w-1:0] rdata;

   //////////////////////////////////////////////////
   // spart
   //////////////////////////////////////////////////
   spart_baud_gen #(.base_div(base_div)) i_baud_gen (
      .clk(clk), .reset(reset), .br_cfg(br_cfg),
      .tx_tick(tx_tick), .rx_tick(rx_tick));

   spart_rx i_rx (
      .clk(clk), .reset(reset), .rxd(rxd),
      .rx_tick(rx_tick), .rx_byte(rx_byte));

   spart_tx i_tx (
      .clk(clk), .reset(reset), .tx_tick(tx_tick),
      .tx_byte(tx_byte), .txd(txd), .tx_busy(tx_busy));

   //////////////////////////////////////////////////
   // controller and memory
   //////////////////////////////////////////////////
   mmu_cmd_ctrl i_cmd_ctrl (
      .clk(clk), .reset(reset),
      .rx_byte(rx_byte), .tx_busy(tx_busy), .tx_byte(tx_byte),
      .mem_req(mem_req), .rdata(rdata),
      .flsh(flsh), .state(state));

   data_mem #(.depth_words(depth_words)) i_data_mem (
      .clk(clk), .mem_req(mem_req), .rdata(rdata));

endmodule

/* tb/mmu_board_props.sv */
// bound assertions on the command controller, flush pulse, write state, state encoding
`timescale 1ns/1ps

module mmu_board_props (
   input logic                 clk,
   input logic                 reset,
   input logic                 flsh,
   input mmu_pkg::mem_req_t    mem_req,
   input mmu_pkg::ctrl_state_e state
);

   int fail_cnt = 0; // assertion failures so far

   // flush is a single clock pulse
   a_flsh_single: assert property (@(posedge clk) disable iff (reset) flsh |=> !flsh)
      else begin
         $error("flsh high on two consecutive clocks");
         fail_cnt++;
      end

   // memory only written from st_write, straight after the last data byte
   a_write_state: assert property (@(posedge clk) disable iff (reset)
      (mem_req.en && mem_req.we) |-> (state == mmu_pkg::st_write) &&
         ($past(state) == mmu_pkg::st_data))
      else begin
         $error("memory write outside st_write, state %0d", state);
         fail_cnt++;
      end

   // no x and no code past st_reply
   a_state_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(state) && (state <= mmu_pkg::st_reply))
      else begin
         $error("undefined controller state %b", state);
         fail_cnt++;
      end

endmodule

bind mmu_cmd_ctrl mmu_board_props i_props (
   .clk(clk), .reset(reset), .flsh(flsh), .mem_req(mem_req), .state(state));

/* tb/mmu_board_tb.sv */
// testbench for the serial memory loader, command table, txd decoder and memory model
`timescale 1ns/1ps

module mmu_board_tb;

   localparam int base_div   = 128;                          // 128/64/32/16 clocks per bit
   localparam int n_tests    = 16;
   localparam int max_cycles = n_tests * 14 * 10 * 128 * 2;  // frames x bits x slowest bit
   localparam logic [7:0] op_w   = 8'h57; // 'W'
   localparam logic [7:0] op_r   = 8'h52; // 'R'
   localparam logic [7:0] op_f   = 8'h46; // 'F'
   localparam logic [7:0] op_unk = 8'h3F; // '?' no such command
   localparam logic [7:0] ack    = 8'h4B; // 'K'
   localparam logic [7:0] nak    = 8'h45; // 'E'

   typedef struct packed {
      logic [1:0]  br;
      logic [7:0]  op;
      logic [13:0] addr;
      logic [63:0] data; // random, writes only
      logic [7:0]  exp;  // single byte reply
      logic        bad;  // opcode frame with low stop bit
   } test_vec_t;

   logic       clk = 1'b0;
   logic       reset, rxd;
   logic [1:0] br_cfg;
   logic       txd, flsh;
   logic [3:0] state;

   test_vec_t   tests [n_tests];
   logic [63:0] ref_mem [256]; // memory model, wraps at depth
   logic [7:0]  rx_q [$];      // bytes decoded from txd
   int          cycles = 0;
   int          errors = 0;
   int          checks = 0;
   int          failed = 0;
   int          flsh_pulses = 0;

   mmu_board #(.base_div(base_div), .depth_words(256)) i_mmu_board (
      .clk(clk), .reset(reset), .rxd(rxd), .br_cfg(br_cfg),
      .txd(txd), .state(state), .flsh(flsh));

   always #50 clk = ~clk; // 100 ns period

   // run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("timeout, run stopped after %0d cycles", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   always @(negedge clk) begin
      if (flsh === 1'b1)
         flsh_pulses++;
   end

   function automatic int bit_time(input logic [1:0] br);
      return base_div >> br;
   endfunction

   function automatic string op_name(input test_vec_t t);
      if (t.bad)
         return "bad stop";
      case (t.op)
         op_w:    return "write";
         op_r:    return "read";
         op_f:    return "flush";
         default: return "unknown";
      endcase
   endfunction

   //////////////////////////////////////////////////
   // serial line
   //////////////////////////////////////////////////
   task automatic send_byte(input logic [7:0] b, input logic bad_stop);
      logic [9:0] frame;
      frame = {~bad_stop, b, 1'b0}; // stop, data lsb first, start
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         rxd <= frame[i];
         repeat (bit_time(br_cfg) - 1) @(posedge clk);
      end
      if (bad_stop) begin
         @(posedge clk);
         rxd <= 1'b1; // back to mark
      end
   endtask

   task automatic send_addr(input logic [13:0] a);
      send_byte({2'b00, a[13:8]}, 1'b0); // high byte first
      send_byte(a[7:0], 1'b0);
   endtask

   // txd decoder, mid-bit samples from the start edge
   initial begin : txd_decoder
      logic [7:0] b;
      int         bt;
      forever begin
         @(negedge clk);
         if (!reset && txd === 1'b0) begin
            bt = bit_time(br_cfg);
            repeat (bt / 2) @(negedge clk);
            if (txd !== 1'b0) begin
               errors++;
               $display("start bit on txd shorter than half a bit at %0t", $time);
            end
            for (int i = 0; i < 8; i++) begin
               repeat (bt) @(negedge clk);
               b[i] = txd;
            end
            repeat (bt) @(negedge clk);
            if (txd !== 1'b1) begin
               errors++;
               $display("stop bit on txd read low at %0t", $time);
            end
            rx_q.push_back(b);
         end
      end
   end

   task automatic get_byte(output logic [7:0] b);
      int waited;
      waited = 0;
      b = 8'h00;
      while (rx_q.size() == 0 && waited < 40 * bit_time(br_cfg)) begin
         @(negedge clk);
         waited++;
      end
      if (rx_q.size() != 0)
         b = rx_q.pop_front();
      else begin
         errors++;
         $display("no byte arrived on txd within 40 bit times at %0t", $time);
      end
   endtask

   task automatic set_rate(input logic [1:0] br);
      repeat (2 * bit_time(br_cfg)) @(posedge clk); // last frame drains
      br_cfg <= br;
      @(posedge clk);
   endtask

   //////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////
   task automatic fill_table();
      tests[0]  = '{2'd0, op_w,   14'h0010, 64'd0, ack,   1'b0};
      tests[1]  = '{2'd0, op_r,   14'h0010, 64'd0, 8'h00, 1'b0};
      tests[2]  = '{2'd1, op_w,   14'h0021, 64'd0, ack,   1'b0};
      tests[3]  = '{2'd2, op_w,   14'h00A2, 64'd0, ack,   1'b0};
      tests[4]  = '{2'd3, op_w,   14'h0305, 64'd0, ack,   1'b0}; // wraps to 05
      tests[5]  = '{2'd3, op_r,   14'h00A2, 64'd0, 8'h00, 1'b0};
      tests[6]  = '{2'd2, op_r,   14'h0005, 64'd0, 8'h00, 1'b0};
      tests[7]  = '{2'd1, op_r,   14'h0021, 64'd0, 8'h00, 1'b0};
      tests[8]  = '{2'd2, op_f,   14'h0000, 64'd0, ack,   1'b0};
      tests[9]  = '{2'd2, op_r,   14'h0010, 64'd0, 8'h00, 1'b0}; // after flush
      tests[10] = '{2'd1, op_unk, 14'h0000, 64'd0, nak,   1'b0};
      tests[11] = '{2'd1, op_r,   14'h0305, 64'd0, 8'h00, 1'b0};
      tests[12] = '{2'd0, op_f,   14'h0000, 64'd0, 8'h00, 1'b1};
      tests[13] = '{2'd3, op_r,   14'h0021, 64'd0, 8'h00, 1'b0};
      tests[14] = '{2'd3, op_w,   14'h3FF3, 64'd0, ack,   1'b0}; // wraps to f3
      tests[15] = '{2'd1, op_r,   14'h00F3, 64'd0, 8'h00, 1'b0};
      for (int i = 0; i < n_tests; i++) begin
         if (tests[i].op == op_w)
            tests[i].data = {$urandom(), $urandom()};
      end
   endtask

   task automatic check_idle();
      for (int c = 0; c < 200 && errors == 0; c++) begin
         @(negedge clk);
         checks++;
         if (txd !== 1'b1) begin
            errors++;
            $display("CHECK FAILED at %0t: txd got %b expected 1", $time, txd);
         end
         if (flsh !== 1'b0) begin
            errors++;
            $display("CHECK FAILED at %0t: flsh got %b expected 0", $time, flsh);
         end
         if (state !== 4'd0) begin
            errors++;
            $display("CHECK FAILED at %0t: state got %0d expected 0", $time, state);
         end
      end
      failed += (errors != 0);
      $display("test reset idle: %s", (errors == 0) ? "ok" : "failed");
   endtask

   task automatic run_test(input int idx);
      test_vec_t   t;
      logic [7:0]  got;
      logic [63:0] word;
      logic        quiet;
      int          errs_before;
      t = tests[idx];
      errs_before = errors;
      set_rate(t.br);
      if (rx_q.size() != 0) begin
         errors++;
         $display("%0d stray bytes on txd before test %0d", rx_q.size(), idx);
         rx_q.delete();
      end
      flsh_pulses = 0;
      if (t.bad) begin
         send_byte(t.op, 1'b1);
         quiet = 1'b1;
         repeat (20 * bit_time(t.br)) begin
            @(negedge clk);
            if (txd !== 1'b1)
               quiet = 1'b0;
         end
         checks++;
         if (!quiet || flsh_pulses != 0) begin
            errors++;
            $display("frame with low stop bit was acted on at %0t", $time);
         end
      end else if (t.op == op_r) begin
         send_byte(op_r, 1'b0);
         send_addr(t.addr);
         word = '0;
         for (int k = 0; k < 8; k++) begin
            get_byte(got);
            word = {word[55:0], got}; // msb byte first
         end
         checks++;
         if (word !== ref_mem[t.addr[7:0]]) begin
            errors++;
            $display("CHECK FAILED at %0t: read word got %h expected %h",
                     $time, word, ref_mem[t.addr[7:0]]);
         end
      end else begin
         send_byte(t.op, 1'b0);
         if (t.op == op_w) begin
            send_addr(t.addr);
            for (int k = 7; k >= 0; k--)
               send_byte(t.data[8*k +: 8], 1'b0);
            ref_mem[t.addr[7:0]] = t.data;
         end
         get_byte(got);
         checks++;
         if (got !== t.exp) begin
            errors++;
            $display("CHECK FAILED at %0t: txd reply got %h expected %h", $time, got, t.exp);
         end
         if (t.op == op_f) begin
            checks++;
            if (flsh_pulses != 1) begin
               errors++;
               $display("CHECK FAILED at %0t: flsh pulses got %0d expected 1",
                        $time, flsh_pulses);
            end
         end
      end
      failed += (errors != errs_before);
      $display("test %0d: %s, br_cfg %0d, addr %h, %s", idx, op_name(t), t.br, t.addr,
               (errors == errs_before) ? "ok" : "failed");
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin
      void'($urandom(32'hea91_d79b));
      reset  = 1'b1;
      rxd    = 1'b1; // mark
      br_cfg = 2'd0;
      fill_table();
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      check_idle();
      for (int i = 0; i < n_tests; i++)
         run_test(i);
      repeat (4 * base_div) @(posedge clk);
      if (rx_q.size() != 0) begin
         errors++;
         $display("%0d stray bytes on txd at the end of the run", rx_q.size());
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               n_tests + 1, failed, checks, errors, i_mmu_board.i_cmd_ctrl.i_props.fail_cnt);
      if (errors == 0 && failed == 0 && i_mmu_board.i_cmd_ctrl.i_props.fail_cnt == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* mmu_loader.f */
common/mmu_pkg.sv
spart/spart_baud_gen.sv
spart/spart_rx.sv
spart/spart_tx.sv
design/data_mem.sv
design/mmu_cmd_ctrl.sv
design/mmu_board.sv
tb/mmu_board_props.sv
tb/mmu_board_tb.sv

/* Bender.yml */
package:
  name: mmu_loader

sources:
  # shared package first
  - common/mmu_pkg.sv
  # serial port
  - spart/spart_baud_gen.sv
  - spart/spart_rx.sv
  - spart/spart_tx.sv
  # controller, memory and top level
  - design/data_mem.sv
  - design/mmu_cmd_ctrl.sv
  - design/mmu_board.sv
  # testbench
  - target: simulation
    files:
      - tb/mmu_board_props.sv
      - tb/mmu_board_tb.sv
